// ==== Makefile ====
BIN := obj_dir/Vtb_zpu_ctrl

.PHONY: all run clean

all: run

$(BIN): sim.f $(wildcard hw/*.sv bench/*.sv)
	verilator --binary --timing --assert -f sim.f --top-module tb_zpu_ctrl -o Vtb_zpu_ctrl

run: $(BIN)
	./$(BIN) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_zpu_ctrl.sv ====
// Testbench for the control and status block
// Random host accesses, SFP pin toggles and stream taps checked against a model
`timescale 1ns/1ps

module tb_zpu_ctrl;

   localparam int N_WR       = 120;  // Register writes
   localparam int N_ID       = 40;   // Identity and unmapped reads
   localparam int N_TMR      = 20;
   localparam int N_SFP      = 40;   // Rounds of two reads
   localparam int N_PKT      = 60;
   localparam int N_ACCESS   = N_WR + N_ID + N_TMR + 1 + 2 * N_SFP + N_PKT;
   localparam int MAX_CYCLES = 100 + 12 * N_ACCESS;  // Access, gap and checks fit in 12

   logic                      clk, rst;
   zpu_ctrl_pkg::bus_req_t    bus_req;
   zpu_ctrl_pkg::sfp_pins_t   sfp0, sfp1;
   logic [15:0]               gmii0, gmii1;
   zpu_ctrl_pkg::stream_tap_t eth0_tx, eth0_rx, eth1_tx, eth1_rx;
   logic                      ack;
   logic [31:0]               rdata;
   zpu_ctrl_pkg::set_bus_t    set_bus;
   logic [3:0]                sw_rst;
   logic [15:0]               leds;
   logic [31:0]               debug;
   logic [1:0]                rs0, rs1;

   logic [31:0] lfsr;
   int          checks, errors, cycle_cnt, step_cnt, stb_step;
   logic        taps_on;                        // Random stream traffic
   logic [31:0] cnt0_now, cnt0_prev, cnt0_ack;  // Packet ends, port 0
   logic [31:0] cnt1_now, cnt1_prev, cnt1_ack;
   logic [3:0]  m_sw_rst;
   logic [15:0] m_leds;
   logic [31:0] m_debug;
   logic [1:0]  m_rs0, m_rs1;
   logic [2:0]  m_pins0, m_pins1, m_flags0, m_flags1;

   zpu_ctrl_top #(.SB_ADDRW(8)) u_dut (
      .clk(clk), .rst(rst), .bus_req_i(bus_req), .ack_o(ack), .rdata_o(rdata),
      .set_bus_o(set_bus), .sfp0_i(sfp0), .sfp1_i(sfp1),
      .gmii_status0_i(gmii0), .gmii_status1_i(gmii1),
      .eth0_tx_i(eth0_tx), .eth0_rx_i(eth0_rx), .eth1_tx_i(eth1_tx), .eth1_rx_i(eth1_rx),
      .sw_rst_o(sw_rst), .leds_o(leds), .debug_o(debug),
      .sfp0_rs_drive_o(rs0), .sfp1_rs_drive_o(rs1)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAIL");
         $finish;
      end
   end

   // ------------------------------
   // Helpers
   // ------------------------------
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // Galois step
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [31:0] pkt_end(input zpu_ctrl_pkg::stream_tap_t t);
      return (t.valid && t.ready && t.last) ? 32'd1 : 32'd0;  // One packet end
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Next edge plus 1 ns, new tap values, model counts follow
   task automatic next_cycle();
      @(posedge clk);
      #1;
      step_cnt++;
      eth0_tx = taps_on ? 3'(rand_bits(3)) : 3'b000;
      eth0_rx = taps_on ? 3'(rand_bits(3)) : 3'b000;
      eth1_tx = taps_on ? 3'(rand_bits(3)) : 3'b000;
      eth1_rx = taps_on ? 3'(rand_bits(3)) : 3'b000;
      cnt0_prev = cnt0_now;  // Ends already visible at the next edge
      cnt1_prev = cnt1_now;
      cnt0_now  = cnt0_now + pkt_end(eth0_tx) + pkt_end(eth0_rx);
      cnt1_now  = cnt1_now + pkt_end(eth1_tx) + pkt_end(eth1_rx);
   endtask

   // One host access, ack timing and settings bus checked on the way
   task automatic bus_access(input logic we, input logic [7:0] wadr, input logic [31:0] wdat,
                             output logic [31:0] rd);
      bus_req.stb = 1'b1;
      bus_req.we  = we;
      bus_req.adr = {6'(rand_bits(6)), wadr, 2'(rand_bits(2))};  // Ignored bits random
      bus_req.dat = wdat;
      stb_step    = step_cnt;
      @(negedge clk);
      check_val("ack_o", 32'(ack), 32'd0);
      next_cycle();
      bus_req.stb = 1'b0;
      @(negedge clk);
      check_val("ack_o", 32'(ack), 32'd1);
      check_val("set_bus_o.stb", 32'(set_bus.stb), 32'(we));
      if (we) begin
         check_val("set_bus_o.addr", 32'(set_bus.addr), 32'(wadr));
         check_val("set_bus_o.data", set_bus.data, wdat);
      end
      rd       = rdata;
      cnt0_ack = cnt0_prev;
      cnt1_ack = cnt1_prev;
      next_cycle();
      @(negedge clk);
      check_val("ack_o", 32'(ack), 32'd0);  // Single-cycle ack
      check_val("rdata_o", rdata, 32'd0);
      next_cycle();
   endtask

   task automatic check_regs();
      @(negedge clk);
      check_val("sw_rst_o", 32'(sw_rst), 32'(m_sw_rst));
      check_val("leds_o", 32'(leds), 32'(m_leds));
      check_val("debug_o", debug, m_debug);
      check_val("sfp0_rs_drive_o", 32'(rs0), 32'(m_rs0));
      check_val("sfp1_rs_drive_o", 32'(rs1), 32'(m_rs1));
      next_cycle();
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      logic [31:0] rd, wdat, exp, t_prev;
      logic [7:0]  wadr;
      logic [2:0]  new0, new1;
      logic        port;
      int          s_prev, sel;
      clk = 1'b0;
      rst = 1'b1;
      lfsr = 32'h933c;
      bus_req = '0;
      sfp0 = '0;
      sfp1 = '0;
      gmii0 = '0;
      gmii1 = '0;
      {eth0_tx, eth0_rx, eth1_tx, eth1_rx} = '0;
      {checks, errors, cycle_cnt, step_cnt, stb_step} = '0;
      taps_on = 1'b0;
      {cnt0_now, cnt0_prev, cnt0_ack, cnt1_now, cnt1_prev, cnt1_ack} = '0;
      {m_sw_rst, m_leds, m_debug, m_rs0, m_rs1} = '0;
      {m_pins0, m_pins1, m_flags0, m_flags1} = '0;
      repeat (10) @(posedge clk);
      #1 rst = 1'b0;
      check_regs();  // Reset values

      // Setting registers, unused addresses mixed in
      for (int n = 0; n < N_WR; n++) begin
         wadr = (rand_bits(2) == 0) ? 8'(rand_bits(8)) : 8'(rand_bits(3));
         wdat = rand_bits(32);
         bus_access(1'b1, wadr, wdat, rd);
         case (wadr)
            zpu_ctrl_pkg::SR_SW_RST:    m_sw_rst = wdat[3:0];
            zpu_ctrl_pkg::SR_LEDS:      m_leds   = wdat[15:0];
            zpu_ctrl_pkg::SR_DEBUG:     m_debug  = wdat;
            zpu_ctrl_pkg::SR_SFP_CTRL0: m_rs0    = wdat[1:0];
            zpu_ctrl_pkg::SR_SFP_CTRL1: m_rs1    = wdat[1:0];
            default: ;
         endcase
         check_regs();
      end

      // Identity words and unmapped reads
      for (int n = 0; n < N_ID; n++) begin
         sel = int'(rand_bits(2));
         wadr = (sel == 0) ? 8'd0 : (sel == 1) ? 8'd4 : 8'(7 + rand_bits(8) % 249);
         exp  = (sel == 0) ? 32'h02300100 : (sel == 1) ? 32'h0badc0de : 32'd0;
         bus_access(1'b0, wadr, 32'd0, rd);
         check_val("rdata_o", rd, exp);
      end

      // Timer deltas match strobe spacing
      bus_access(1'b0, zpu_ctrl_pkg::RB_COUNTER, 32'd0, rd);
      t_prev = rd;
      s_prev = stb_step;
      for (int n = 0; n < N_TMR; n++) begin
         repeat (rand_bits(3)) next_cycle();
         bus_access(1'b0, zpu_ctrl_pkg::RB_COUNTER, 32'd0, rd);
         check_val("timer delta", rd - t_prev, 32'(stb_step - s_prev));
         t_prev = rd;
         s_prev = stb_step;
      end

      // SFP levels and sticky flags
      for (int n = 0; n < N_SFP; n++) begin
         new0 = 3'(rand_bits(3));
         new1 = 3'(rand_bits(3));
         m_flags0 = m_flags0 | (new0 ^ m_pins0);
         m_flags1 = m_flags1 | (new1 ^ m_pins1);
         m_pins0 = new0;
         m_pins1 = new1;
         sfp0 = new0;
         sfp1 = new1;
         gmii0 = 16'(rand_bits(16));
         gmii1 = 16'(rand_bits(16));
         repeat (4 + rand_bits(2)) next_cycle();  // Sync and flag settle
         port = rand_bits(1) == 1;
         wadr = port ? zpu_ctrl_pkg::RB_SFP_STATUS1 : zpu_ctrl_pkg::RB_SFP_STATUS0;
         for (int k = 0; k < 2; k++) begin
            exp = port ? {gmii1, 10'h0, m_flags1, m_pins1} : {gmii0, 10'h0, m_flags0, m_pins0};
            bus_access(1'b0, wadr, 32'd0, rd);
            check_val(port ? "sfp1 status" : "sfp0 status", rd, exp);
            if (port)
               m_flags1 = 3'b000;  // Read clears
            else
               m_flags0 = 3'b000;
         end
      end

      // Packet counters under random stream traffic
      taps_on = 1'b1;
      for (int n = 0; n < N_PKT; n++) begin
         repeat (rand_bits(3)) next_cycle();
         port = rand_bits(1) == 1;
         wadr = port ? zpu_ctrl_pkg::RB_ETH1_PKT_CNT : zpu_ctrl_pkg::RB_ETH0_PKT_CNT;
         bus_access(1'b0, wadr, 32'd0, rd);
         check_val(port ? "eth1 pkt count" : "eth0 pkt count", rd, port ? cnt1_ack : cnt0_ack);
      end
      taps_on = 1'b0;

      $display("Checks: %0d  errors: %0d  cycles: %0d", checks, errors, cycle_cnt);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== bench/zpu_ctrl_props.sv ====
// Bus timing assertions for the settings bridge
// Ack latency and settings strobe origin
`timescale 1ns/1ps

module zpu_ctrl_props (
   input logic                   clk,
   input logic                   rst,
   input zpu_ctrl_pkg::bus_req_t bus_req_i,
   input zpu_ctrl_pkg::set_bus_t set_bus_i,
   input logic                   ack_i
);

   // ------------------------------
   // Ack exactly one cycle after a strobe
   // ------------------------------
   a_ack_follows_stb: assert property (@(posedge clk) disable iff (rst)
      bus_req_i.stb |=> ack_i)
      else $error("Ack missing one cycle after a request strobe");

   a_no_stray_ack: assert property (@(posedge clk) disable iff (rst)
      ack_i |-> $past(bus_req_i.stb))
      else $error("Ack without a request strobe one cycle earlier");

   // Settings strobe only from a write
   a_set_from_write: assert property (@(posedge clk) disable iff (rst)
      set_bus_i.stb |-> $past(bus_req_i.stb && bus_req_i.we))
      else $error("Settings strobe without a preceding write request");

endmodule

bind settings_bridge zpu_ctrl_props u_props (
   .clk(clk), .rst(rst), .bus_req_i(bus_req_i), .set_bus_i(set_bus_o), .ack_i(ack_o)
);

// ==== hw/ctrl_regs.sv ====
// Settings-bus register bank
// Soft reset, LEDs, debug word and SFP rate-select drive
`timescale 1ns/1ps

module ctrl_regs #(
   parameter int SB_ADDRW = 8
) (
   input  logic                   clk,
   input  logic                   rst,
   input  zpu_ctrl_pkg::set_bus_t set_bus_i,
   output logic [3:0]             sw_rst_o,
   output logic [15:0]            leds_o,
   output logic [31:0]            debug_o,
   output logic [1:0]             sfp0_rs_drive_o,
   output logic [1:0]             sfp1_rs_drive_o
);

   logic [SB_ADDRW-1:0] addr;     // Decoded part of the settings address
   logic [31:0]         debug_q;  // Debug register before the output stage

   assign addr = set_bus_i.addr[SB_ADDRW-1:0];

   // ------------------------------
   // Register loads
   // ------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         sw_rst_o        <= '0;
         leds_o          <= '0;
         debug_q         <= '0;
         sfp0_rs_drive_o <= 2'b00;  // Not driving
         sfp1_rs_drive_o <= 2'b00;
      end else if (set_bus_i.stb) begin
         case (addr)
            SB_ADDRW'(zpu_ctrl_pkg::SR_SW_RST):    sw_rst_o        <= set_bus_i.data[3:0];
            SB_ADDRW'(zpu_ctrl_pkg::SR_LEDS):      leds_o          <= set_bus_i.data[15:0];
            SB_ADDRW'(zpu_ctrl_pkg::SR_DEBUG):     debug_q         <= set_bus_i.data;
            SB_ADDRW'(zpu_ctrl_pkg::SR_SFP_CTRL0): sfp0_rs_drive_o <= set_bus_i.data[1:0];
            SB_ADDRW'(zpu_ctrl_pkg::SR_SFP_CTRL1): sfp1_rs_drive_o <= set_bus_i.data[1:0];
            default: ;  // Unmapped address, nothing loads
         endcase
      end
   end

   // Extra stage toward the analyzer pins
   always_ff @(posedge clk) begin
      if (rst)
         debug_o <= '0;
      else
         debug_o <= debug_q;
   end

endmodule

// ==== hw/eth_pkt_counter.sv ====
// Packet end counter for one Ethernet port
// Counts tx and rx ends, two in a cycle when both end together
`timescale 1ns/1ps

module eth_pkt_counter (
   input  logic                      clk,
   input  logic                      rst,
   input  zpu_ctrl_pkg::stream_tap_t tx_i,
   input  zpu_ctrl_pkg::stream_tap_t rx_i,
   output logic [31:0]               count_o
);

   logic       tx_end;  // Last beat accepted on tx
   logic       rx_end;
   logic [1:0] n_ends;  // Ends this cycle, 0 to 2

   assign tx_end = tx_i.valid & tx_i.ready & tx_i.last;
   assign rx_end = rx_i.valid & rx_i.ready & rx_i.last;
   assign n_ends = {1'b0, tx_end} + {1'b0, rx_end};

   always_ff @(posedge clk) begin
      if (rst)
         count_o <= '0;
      else
         count_o <= count_o + 32'(n_ends);  // Wraps at 2^32
   end

endmodule

// ==== hw/readback_mux.sv ====
// Readback word select with the free-running cycle timer
// Also decodes the SFP flag clears from the read strobe
`timescale 1ns/1ps

module readback_mux #(
   parameter int SB_ADDRW = 8
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [SB_ADDRW-1:0]         rb_addr_i,
   input  logic                        rb_rd_stb_i,
   input  logic [5:0]                  sfp0_status_i,
   input  logic [5:0]                  sfp1_status_i,
   input  logic [15:0]                 gmii_status0_i,
   input  logic [15:0]                 gmii_status1_i,
   input  logic [31:0]                 eth0_count_i,
   input  logic [31:0]                 eth1_count_i,
   output logic [zpu_ctrl_pkg::DW-1:0] rb_data_o,
   output logic                        sfp0_clear_o,
   output logic                        sfp1_clear_o
);

   logic [31:0] timer_q;  // Software timer

   always_ff @(posedge clk) begin
      if (rst)
         timer_q <= '0;
      else
         timer_q <= timer_q + 32'd1;
   end

   // ------------------------------
   // Word select
   // ------------------------------
   always_comb begin
      case (rb_addr_i)
         SB_ADDRW'(zpu_ctrl_pkg::RB_COMPAT):
            rb_data_o = {zpu_ctrl_pkg::PRODUCT_ID, zpu_ctrl_pkg::COMPAT_MAJOR,
                         zpu_ctrl_pkg::COMPAT_MINOR};
         SB_ADDRW'(zpu_ctrl_pkg::RB_COUNTER):      rb_data_o = timer_q;
         SB_ADDRW'(zpu_ctrl_pkg::RB_SFP_STATUS0):  rb_data_o = {gmii_status0_i, 10'h0, sfp0_status_i};
         SB_ADDRW'(zpu_ctrl_pkg::RB_SFP_STATUS1):  rb_data_o = {gmii_status1_i, 10'h0, sfp1_status_i};
         SB_ADDRW'(zpu_ctrl_pkg::RB_BUILD_ID):     rb_data_o = zpu_ctrl_pkg::BUILD_ID;
         SB_ADDRW'(zpu_ctrl_pkg::RB_ETH0_PKT_CNT): rb_data_o = eth0_count_i;
         SB_ADDRW'(zpu_ctrl_pkg::RB_ETH1_PKT_CNT): rb_data_o = eth1_count_i;
         default:                                  rb_data_o = '0;  // Unmapped reads zero
      endcase
   end

   // Reading a status word clears its flags at the next edge
   assign sfp0_clear_o = rb_rd_stb_i && (rb_addr_i == SB_ADDRW'(zpu_ctrl_pkg::RB_SFP_STATUS0));
   assign sfp1_clear_o = rb_rd_stb_i && (rb_addr_i == SB_ADDRW'(zpu_ctrl_pkg::RB_SFP_STATUS1));

endmodule

// ==== hw/settings_bridge.sv ====
// Host strobe bus to settings bus and readback strobe
// Fixed one-cycle acknowledge for reads and writes
`timescale 1ns/1ps

module settings_bridge #(
   parameter int SB_ADDRW = 8
) (
   input  logic                           clk,
   input  logic                           rst,
   input  zpu_ctrl_pkg::bus_req_t         bus_req_i,
   input  logic [zpu_ctrl_pkg::DW-1:0]    rb_data_i,
   output zpu_ctrl_pkg::set_bus_t         set_bus_o,
   output logic [SB_ADDRW-1:0]            rb_addr_o,
   output logic                           rb_rd_stb_o,
   output logic                           ack_o,
   output logic [zpu_ctrl_pkg::DW-1:0]    rdata_o
);

   logic [SB_ADDRW-1:0]         word_adr;  // Byte address to word address
   logic                        set_stb_q;
   logic [7:0]                  set_addr_q;
   logic [zpu_ctrl_pkg::DW-1:0] set_data_q;
   logic [SB_ADDRW-1:0]         adr_q;
   logic                        rd_stb_q;
   logic                        ack_q;

   assign word_adr = bus_req_i.adr[2 +: SB_ADDRW];

   // Strobes and ack
   always_ff @(posedge clk) begin
      if (rst) begin
         set_stb_q <= 1'b0;
         rd_stb_q  <= 1'b0;
         ack_q     <= 1'b0;
      end else begin
         set_stb_q <= bus_req_i.stb & bus_req_i.we;
         rd_stb_q  <= bus_req_i.stb & ~bus_req_i.we;
         ack_q     <= bus_req_i.stb;  // Every access acks next cycle
      end
   end

   // Address and data held until the next request
   always_ff @(posedge clk) begin
      if (bus_req_i.stb) begin
         adr_q      <= word_adr;
         set_addr_q <= 8'(word_adr);
         set_data_q <= bus_req_i.dat;
      end
   end

   assign set_bus_o   = '{stb: set_stb_q, addr: set_addr_q, data: set_data_q};
   assign rb_addr_o   = adr_q;
   assign rb_rd_stb_o = rd_stb_q;
   assign ack_o       = ack_q;
   assign rdata_o     = ack_q ? rb_data_i : '0;  // Zero outside the ack cycle

endmodule

// ==== hw/sfp_status.sv ====
// One SFP port's status pins
// Two-stage sync plus sticky change flags, cleared on read
`timescale 1ns/1ps

module sfp_status (
   input  logic                    clk,
   input  logic                    rst,
   input  zpu_ctrl_pkg::sfp_pins_t pins_i,
   input  logic                    clear_i,
   output logic [5:0]              status_o
);

   logic [2:0] sync1_q;  // First stage, may be metastable
   logic [2:0] sync2_q;  // Stable levels
   logic [2:0] chgd_q;   // Sticky change flags

   always_ff @(posedge clk) begin
      if (rst) begin
         sync1_q <= '0;
         sync2_q <= '0;
         chgd_q  <= '0;
      end else begin
         sync1_q <= {pins_i.mod_abs, pins_i.tx_fault, pins_i.rx_los};
         sync2_q <= sync1_q;
         if (clear_i)
            chgd_q <= '0;  // Clear wins over a change this cycle
         else
            chgd_q <= chgd_q | (sync1_q ^ sync2_q);
      end
   end

   assign status_o = {chgd_q, sync2_q};  // Flags over levels

endmodule

// ==== hw/zpu_ctrl_pkg.sv ====
// Shared definitions for the control and status block
// Register map, identity words and bus structs

package zpu_ctrl_pkg;

   localparam int DW = 32;  // Data word width

   // ------------------------------
   // Bus structs
   // ------------------------------
   typedef struct packed {
      logic          stb;  // One-cycle request
      logic          we;   // High for write
      logic [15:0]   adr;  // Byte address
      logic [DW-1:0] dat;  // Write data
   } bus_req_t;

   typedef struct packed {
      logic          stb;   // One-cycle load strobe
      logic [7:0]    addr;  // Word address
      logic [DW-1:0] data;
   } set_bus_t;

   typedef struct packed {
      logic mod_abs;   // Module absent
      logic tx_fault;
      logic rx_los;    // Loss of signal
   } sfp_pins_t;

   typedef struct packed {
      logic valid;
      logic ready;
      logic last;  // End of packet beat
   } stream_tap_t;

   // ------------------------------
   // Settings addresses
   // ------------------------------
   localparam logic [7:0] SR_SW_RST    = 8'd0;
   localparam logic [7:0] SR_LEDS      = 8'd1;
   localparam logic [7:0] SR_DEBUG     = 8'd2;
   localparam logic [7:0] SR_SFP_CTRL0 = 8'd3;
   localparam logic [7:0] SR_SFP_CTRL1 = 8'd4;

   // Readback addresses
   localparam logic [7:0] RB_COMPAT       = 8'd0;
   localparam logic [7:0] RB_COUNTER      = 8'd1;
   localparam logic [7:0] RB_SFP_STATUS0  = 8'd2;
   localparam logic [7:0] RB_SFP_STATUS1  = 8'd3;
   localparam logic [7:0] RB_BUILD_ID     = 8'd4;
   localparam logic [7:0] RB_ETH0_PKT_CNT = 8'd5;
   localparam logic [7:0] RB_ETH1_PKT_CNT = 8'd6;

   // Identity
   localparam logic [15:0] PRODUCT_ID   = 16'h0230;
   localparam logic [7:0]  COMPAT_MAJOR = 8'd1;
   localparam logic [7:0]  COMPAT_MINOR = 8'd0;
   localparam logic [31:0] BUILD_ID     = 32'h0badc0de;  // Source revision tag

endpackage

// ==== hw/zpu_ctrl_top.sv ====
// Control and status block top level
// Bridge, setting registers, SFP latches, packet counters and readback
`timescale 1ns/1ps

module zpu_ctrl_top #(
   parameter int SB_ADDRW = 8  // Settings and readback word address width
) (
   input  logic                        clk,
   input  logic                        rst,
   // Host bus
   input  zpu_ctrl_pkg::bus_req_t      bus_req_i,
   output logic                        ack_o,
   output logic [zpu_ctrl_pkg::DW-1:0] rdata_o,
   output zpu_ctrl_pkg::set_bus_t      set_bus_o,
   // SFP and PHY status
   input  zpu_ctrl_pkg::sfp_pins_t     sfp0_i,
   input  zpu_ctrl_pkg::sfp_pins_t     sfp1_i,
   input  logic [15:0]                 gmii_status0_i,
   input  logic [15:0]                 gmii_status1_i,
   // Ethernet stream taps
   input  zpu_ctrl_pkg::stream_tap_t   eth0_tx_i,
   input  zpu_ctrl_pkg::stream_tap_t   eth0_rx_i,
   input  zpu_ctrl_pkg::stream_tap_t   eth1_tx_i,
   input  zpu_ctrl_pkg::stream_tap_t   eth1_rx_i,
   // Control outputs
   output logic [3:0]                  sw_rst_o,
   output logic [15:0]                 leds_o,
   output logic [31:0]                 debug_o,
   output logic [1:0]                  sfp0_rs_drive_o,  // Drive-low enables
   output logic [1:0]                  sfp1_rs_drive_o
);

   zpu_ctrl_pkg::set_bus_t      set_bus;
   logic [SB_ADDRW-1:0]         rb_addr;
   logic                        rb_rd_stb;
   logic [zpu_ctrl_pkg::DW-1:0] rb_data;
   logic [5:0]                  sfp0_status, sfp1_status;
   logic                        sfp0_clear, sfp1_clear;
   logic [31:0]                 eth0_count, eth1_count;

   assign set_bus_o = set_bus;  // Settings bus also leaves the block

   // ------------------------------
   // Bus side
   // ------------------------------
   settings_bridge #(.SB_ADDRW(SB_ADDRW)) u_bridge (
      .clk(clk), .rst(rst),
      .bus_req_i(bus_req_i), .rb_data_i(rb_data),
      .set_bus_o(set_bus), .rb_addr_o(rb_addr), .rb_rd_stb_o(rb_rd_stb),
      .ack_o(ack_o), .rdata_o(rdata_o)
   );

   ctrl_regs #(.SB_ADDRW(SB_ADDRW)) u_regs (
      .clk(clk), .rst(rst), .set_bus_i(set_bus),
      .sw_rst_o(sw_rst_o), .leds_o(leds_o), .debug_o(debug_o),
      .sfp0_rs_drive_o(sfp0_rs_drive_o), .sfp1_rs_drive_o(sfp1_rs_drive_o)
   );

   readback_mux #(.SB_ADDRW(SB_ADDRW)) u_rb_mux (
      .clk(clk), .rst(rst),
      .rb_addr_i(rb_addr), .rb_rd_stb_i(rb_rd_stb),
      .sfp0_status_i(sfp0_status), .sfp1_status_i(sfp1_status),
      .gmii_status0_i(gmii_status0_i), .gmii_status1_i(gmii_status1_i),
      .eth0_count_i(eth0_count), .eth1_count_i(eth1_count),
      .rb_data_o(rb_data), .sfp0_clear_o(sfp0_clear), .sfp1_clear_o(sfp1_clear)
   );

   // Status side
   sfp_status u_sfp0 (
      .clk(clk), .rst(rst), .pins_i(sfp0_i), .clear_i(sfp0_clear), .status_o(sfp0_status)
   );

   sfp_status u_sfp1 (
      .clk(clk), .rst(rst), .pins_i(sfp1_i), .clear_i(sfp1_clear), .status_o(sfp1_status)
   );

   eth_pkt_counter u_eth0_cnt (
      .clk(clk), .rst(rst), .tx_i(eth0_tx_i), .rx_i(eth0_rx_i), .count_o(eth0_count)
   );

   eth_pkt_counter u_eth1_cnt (
      .clk(clk), .rst(rst), .tx_i(eth1_tx_i), .rx_i(eth1_rx_i), .count_o(eth1_count)
   );

endmodule

// ==== sim.f ====
hw/zpu_ctrl_pkg.sv
hw/settings_bridge.sv
hw/ctrl_regs.sv
hw/sfp_status.sv
hw/eth_pkt_counter.sv
hw/readback_mux.sv
hw/zpu_ctrl_top.sv
bench/zpu_ctrl_props.sv
bench/tb_zpu_ctrl.sv
